// File: Makefile
VERILATOR ?= verilator
VFLAGS    ?= --timing
TOP       := fetch_predictor_tb
FILELIST  := list.f
OBJ_DIR   := obj_dir
LOG       := sim.log

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) --lint-only $(VFLAGS) -f $(FILELIST) --top-module $(TOP)

sim:
	$(VERILATOR) --binary $(VFLAGS) -f $(FILELIST) --top-module $(TOP) --Mdir $(OBJ_DIR)
	./$(OBJ_DIR)/V$(TOP) | tee $(LOG)
	grep -q "^=== PASS ===$$" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

// File: hdl/bp_pkg.sv
/*
 * Branch predictor widths, reset vector, vector types, packed structs
 * and small pc helper functions
 */
`default_nettype none

package bp_pkg;

    localparam int ADDR_W  = 32;
    localparam int INDEX_W = 5;
    localparam int TAG_W   = 24;
    localparam int ENTRIES = 1 << INDEX_W;

    localparam logic [ADDR_W-1:0] RESET_PC = 32'h1c000000;

    typedef logic [ADDR_W-1:0]  addr_t;
    typedef logic [ADDR_W-3:0]  word_addr_t;
    typedef logic [INDEX_W-1:0] index_t;
    typedef logic [TAG_W-1:0]   tag_t;
    typedef logic [1:0]         hist_t;
    typedef logic [1:0]         ctr_t;

    // Local history on top, counter selected by history value
    typedef struct packed {
        hist_t hist;
        ctr_t  ctr3;
        ctr_t  ctr2;
        ctr_t  ctr1;
        ctr_t  ctr0;
    } pattern_t;

    // History 0, all counters weakly not-taken
    localparam pattern_t PAT_INIT = '{
        hist: 2'b00,
        ctr3: 2'b01,
        ctr2: 2'b01,
        ctr1: 2'b01,
        ctr0: 2'b01
    };

    typedef struct packed {
        logic       exist;
        word_addr_t target;
        logic       uncond;
        logic       cond;
    } slot_info_t;

    typedef struct packed {
        logic     vld;
        pattern_t pat;
    } slot_past_t;

    typedef struct packed {
        hist_t g1;
        hist_t g2;
    } guess_t;

    // Resolved branch from execute, slot 0 is the first instruction
    typedef struct packed {
        logic       vld;
        logic       wrong;
        addr_t      pc;
        logic       slot;
        logic       taken;
        word_addr_t target;
        logic       uncond;
        logic       cond;
        addr_t      redirect_pc;
    } ex_update_t;

    function automatic index_t pc_index(input addr_t pc);
        return pc[INDEX_W+2:3];
    endfunction

    function automatic tag_t pc_tag(input addr_t pc);
        return pc[ADDR_W-1:INDEX_W+3];
    endfunction

    // Counter chosen by a 2-bit history
    function automatic ctr_t sel_ctr(input pattern_t p, input hist_t h);
        case (h)
            2'd0:    return p.ctr0;
            2'd1:    return p.ctr1;
            2'd2:    return p.ctr2;
            default: return p.ctr3;
        endcase
    endfunction

endpackage

`default_nettype wire

// File: hdl/branch_target_buffer.sv
/*
 * Two-bank tagged branch target buffer, one bank per instruction slot,
 * filled from execute updates
 */
`timescale 1ns/1ps
`default_nettype none

module branch_target_buffer (
    input  wire                      clk,
    input  wire                      rstn,
    input  wire bp_pkg::addr_t       pc_now,
    input  wire bp_pkg::ex_update_t  ex,
    output bp_pkg::slot_info_t       info1,
    output bp_pkg::slot_info_t       info2
);

    ////////////////////////////////////////
    // Storage
    ////////////////////////////////////////

    // Bank 0 holds slot 1, bank 1 holds slot 2
    logic               valid  [2][bp_pkg::ENTRIES];
    bp_pkg::tag_t       tag    [2][bp_pkg::ENTRIES];
    bp_pkg::word_addr_t target [2][bp_pkg::ENTRIES];
    logic               uncond [2][bp_pkg::ENTRIES];
    logic               cond   [2][bp_pkg::ENTRIES];

    bp_pkg::index_t     rd_idx;
    bp_pkg::tag_t       rd_tag;
    bp_pkg::index_t     wr_idx;
    logic               wr_en;
    bp_pkg::slot_info_t info [2];

    assign rd_idx = bp_pkg::pc_index(pc_now);
    assign rd_tag = bp_pkg::pc_tag(pc_now);
    assign wr_idx = bp_pkg::pc_index(ex.pc);

    // Only branches that redirect fetch are worth an entry
    assign wr_en = ex.vld && (ex.taken || ex.uncond);

    ////////////////////////////////////////
    // Update from execute
    ////////////////////////////////////////

    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            for (int b = 0; b < 2; b++) begin
                for (int i = 0; i < bp_pkg::ENTRIES; i++) begin
                    valid[b][i] <= 1'b0;
                end
            end
        end else if (wr_en) begin
            valid[ex.slot][wr_idx] <= 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (wr_en) begin
            tag[ex.slot][wr_idx]    <= bp_pkg::pc_tag(ex.pc);
            target[ex.slot][wr_idx] <= ex.target;
            uncond[ex.slot][wr_idx] <= ex.uncond;
            cond[ex.slot][wr_idx]   <= ex.cond;
        end
    end

    ////////////////////////////////////////
    // Lookup
    ////////////////////////////////////////

    always_comb begin
        for (int b = 0; b < 2; b++) begin
            info[b].exist  = valid[b][rd_idx] && (tag[b][rd_idx] == rd_tag);
            info[b].target = target[b][rd_idx];
            info[b].uncond = uncond[b][rd_idx];
            info[b].cond   = cond[b][rd_idx];
        end
    end

    assign info1 = info[0];
    assign info2 = info[1];

endmodule

`default_nettype wire

// File: hdl/fetch_predictor.sv
/*
 * Fetch predictor top with the fetch pc register and redirect
 */
`timescale 1ns/1ps
`default_nettype none

module fetch_predictor (
    input  wire                      clk,
    input  wire                      rstn,
    input  wire                      en,
    input  wire bp_pkg::ex_update_t  ex,
    output bp_pkg::addr_t            pc,
    output bp_pkg::addr_t            pc_new,
    output logic                     branch,
    output logic                     reason
);

    bp_pkg::slot_info_t info1;
    bp_pkg::slot_info_t info2;
    bp_pkg::slot_past_t past1;
    bp_pkg::slot_past_t past2;

    // Redirect from execute has priority over the prediction
    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            pc <= bp_pkg::RESET_PC;
        end else if (ex.vld && ex.wrong) begin
            pc <= ex.redirect_pc;
        end else if (en) begin
            pc <= pc_new;
        end
    end

    branch_target_buffer u_btb (
        .clk    (clk),
        .rstn   (rstn),
        .pc_now (pc),
        .ex     (ex),
        .info1  (info1),
        .info2  (info2)
    );

    pattern_history_table u_pht (
        .clk    (clk),
        .rstn   (rstn),
        .pc_now (pc),
        .ex     (ex),
        .past1  (past1),
        .past2  (past2)
    );

    predict_unit u_predict (
        .clk    (clk),
        .rstn   (rstn),
        .en     (en),
        .pc_now (pc),
        .info1  (info1),
        .info2  (info2),
        .past1  (past1),
        .past2  (past2),
        .ex     (ex),
        .pc_new (pc_new),
        .branch (branch),
        .reason (reason)
    );

endmodule

`default_nettype wire

// File: hdl/guess_log_ram.sv
/*
 * Register-array memory for speculative history entries,
 * clocked write and asynchronous read
 */
`timescale 1ns/1ps
`default_nettype none

module guess_log_ram (
    input  wire                  clk,
    input  wire                  wt_en,
    input  wire bp_pkg::index_t  waddr,
    input  wire bp_pkg::guess_t  wdata,
    input  wire bp_pkg::index_t  raddr,
    output bp_pkg::guess_t       rdata
);

    // One entry per fetch packet index
    bp_pkg::guess_t mem [bp_pkg::ENTRIES];

    always_ff @(posedge clk) begin
        if (wt_en) begin
            mem[waddr] <= wdata;
        end
    end

    // Read sees the old word when the same index is written this cycle
    assign rdata = mem[raddr];

endmodule

`default_nettype wire

// File: hdl/pattern_history_table.sv
/*
 * Two-bank pattern history table, 2-bit local history and four
 * saturating counters per slot, trained by execute outcomes
 */
`timescale 1ns/1ps
`default_nettype none

module pattern_history_table (
    input  wire                      clk,
    input  wire                      rstn,
    input  wire bp_pkg::addr_t       pc_now,
    input  wire bp_pkg::ex_update_t  ex,
    output bp_pkg::slot_past_t       past1,
    output bp_pkg::slot_past_t       past2
);

    logic             rec_vld [2][bp_pkg::ENTRIES];
    bp_pkg::pattern_t rec     [2][bp_pkg::ENTRIES];

    bp_pkg::index_t   rd_idx;
    bp_pkg::index_t   wr_idx;
    bp_pkg::pattern_t trained;

    // Saturating step toward taken or not-taken
    function automatic bp_pkg::ctr_t sat_step(input bp_pkg::ctr_t c, input logic up);
        if (up) begin
            return (c == 2'b11) ? c : c + 2'd1;
        end
        return (c == 2'b00) ? c : c - 2'd1;
    endfunction

    function automatic bp_pkg::pattern_t train(input bp_pkg::pattern_t p, input logic taken);
        bp_pkg::pattern_t n;
        bp_pkg::ctr_t     c;
        n = p;
        c = sat_step(bp_pkg::sel_ctr(p, p.hist), taken);
        case (p.hist)
            2'd0:    n.ctr0 = c;
            2'd1:    n.ctr1 = c;
            2'd2:    n.ctr2 = c;
            default: n.ctr3 = c;
        endcase
        n.hist = {p.hist[0], taken};
        return n;
    endfunction

    assign rd_idx  = bp_pkg::pc_index(pc_now);
    assign wr_idx  = bp_pkg::pc_index(ex.pc);
    assign trained = train(rec[ex.slot][wr_idx], ex.taken);

    // Only conditional branches train the table
    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            for (int b = 0; b < 2; b++) begin
                for (int i = 0; i < bp_pkg::ENTRIES; i++) begin
                    rec_vld[b][i] <= 1'b0;
                    rec[b][i]     <= bp_pkg::PAT_INIT;
                end
            end
        end else if (ex.vld && ex.cond) begin
            rec_vld[ex.slot][wr_idx] <= 1'b1;
            rec[ex.slot][wr_idx]     <= trained;
        end
    end

    assign past1.vld = rec_vld[0][rd_idx];
    assign past1.pat = rec[0][rd_idx];
    assign past2.vld = rec_vld[1][rd_idx];
    assign past2.pat = rec[1][rd_idx];

endmodule

`default_nettype wire

// File: hdl/predict_unit.sv
/*
 * Per-slot direction choice, speculative guess history and
 * next fetch pc selection
 */
`timescale 1ns/1ps
`default_nettype none

module predict_unit (
    input  wire                      clk,
    input  wire                      rstn,
    input  wire                      en,
    input  wire bp_pkg::addr_t       pc_now,
    input  wire bp_pkg::slot_info_t  info1,
    input  wire bp_pkg::slot_info_t  info2,
    input  wire bp_pkg::slot_past_t  past1,
    input  wire bp_pkg::slot_past_t  past2,
    input  wire bp_pkg::ex_update_t  ex,
    output bp_pkg::addr_t            pc_new,
    output logic                     branch,
    output logic                     reason
);

    bp_pkg::index_t             idx;
    bp_pkg::guess_t             guess_rd;
    bp_pkg::guess_t             guess_wr;
    logic [bp_pkg::ENTRIES-1:0] in_guess1;
    logic [bp_pkg::ENTRIES-1:0] in_guess2;
    bp_pkg::hist_t              eff1;
    bp_pkg::hist_t              eff2;
    logic                       dir1;
    logic                       dir2;
    logic                       half;
    logic                       set1;
    logic                       set2;
    bp_pkg::word_addr_t         pick;

    // Direction of one slot from its BTB and PHT answers
    function automatic logic slot_dir(
        input bp_pkg::slot_info_t info,
        input bp_pkg::slot_past_t past,
        input bp_pkg::hist_t      h,
        input bp_pkg::addr_t      here
    );
        bp_pkg::ctr_t c;
        c = bp_pkg::sel_ctr(past.pat, h);
        if (!info.exist) begin
            return 1'b0;
        end
        if (past.vld) begin
            return c[1];
        end
        // No record yet, so backward branches are guessed taken
        return info.uncond || (info.target < here[bp_pkg::ADDR_W-1:2]);
    endfunction

    ////////////////////////////////////////
    // Guess log
    ////////////////////////////////////////

    assign idx = bp_pkg::pc_index(pc_now);

    guess_log_ram u_guess_log (
        .clk   (clk),
        .wt_en (en),
        .waddr (idx),
        .wdata (guess_wr),
        .raddr (idx),
        .rdata (guess_rd)
    );

    // Speculative history wins while the slot is still in guess
    assign eff1 = in_guess1[idx] ? guess_rd.g1 : past1.pat.hist;
    assign eff2 = in_guess2[idx] ? guess_rd.g2 : past2.pat.hist;

    ////////////////////////////////////////
    // Direction and slot selection
    ////////////////////////////////////////

    assign dir1 = slot_dir(info1, past1, eff1, pc_now);
    assign dir2 = slot_dir(info2, past2, eff2, pc_now);

    // Entered at the second slot, first slot is skipped
    assign half   = pc_now[2];
    assign branch = half ? dir2 : (dir1 | dir2);
    assign reason = half | (~dir1 & dir2);

    assign guess_wr.g1 = {eff1[0], branch & ~reason};
    assign guess_wr.g2 = {eff2[0], branch & reason};

    ////////////////////////////////////////
    // In-guess flags
    ////////////////////////////////////////

    assign set1 = en && !half && info1.exist && past1.vld && info1.cond;
    assign set2 = en && !dir1 && info2.exist && past2.vld && info2.cond;

    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            in_guess1 <= '0;
            in_guess2 <= '0;
        end else if (ex.vld && ex.wrong) begin
            // Misprediction makes every speculative entry stale
            in_guess1 <= '0;
            in_guess2 <= '0;
        end else begin
            if (set1) begin
                in_guess1[idx] <= 1'b1;
            end
            if (set2) begin
                in_guess2[idx] <= 1'b1;
            end
        end
    end

    ////////////////////////////////////////
    // Next pc
    ////////////////////////////////////////

    assign pick = reason ? info2.target : info1.target;

    always_comb begin
        if (branch) begin
            pc_new = {pick, 2'b00};
        end else begin
            pc_new = {pc_now[bp_pkg::ADDR_W-1:3], 3'b000} + bp_pkg::addr_t'(8);
        end
    end

endmodule

`default_nettype wire

// File: list.f
hdl/bp_pkg.sv
hdl/guess_log_ram.sv
hdl/branch_target_buffer.sv
hdl/pattern_history_table.sv
hdl/predict_unit.sv
hdl/fetch_predictor.sv
tb/clock_gen.sv
tb/fetch_predictor_tb.sv

// File: tb/clock_gen.sv
/*
 * Testbench clock with a 100 ns period, reset held low for 16 cycles
 */
`timescale 1ns/1ps
`default_nettype none

module clock_gen (
    output logic clk,
    output logic rstn
);

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    // Released a quarter period after a rising edge
    initial begin
        rstn = 1'b0;
        repeat (16) @(posedge clk);
        #25 rstn = 1'b1;
    end

endmodule

`default_nettype wire

// File: tb/fetch_predictor_tb.sv
/*
 * Fetch predictor testbench with LFSR stimulus, reference model,
 * per-cycle compare process, watchdog and report
 */
`timescale 1ns/1ps
`default_nettype none

module fetch_predictor_tb;

    localparam int T1_CYC       = 20;
    localparam int T2_CYC       = 10;
    localparam int T3_CYC       = 12;
    localparam int T4_CYC       = 16;
    localparam int T5_CYC       = 24;
    localparam int T6_CYC       = 16;
    localparam int WATCHDOG_CYC = 16 + T1_CYC + T2_CYC + T3_CYC + T4_CYC + T5_CYC + T6_CYC + 40;

    typedef struct packed {
        bp_pkg::addr_t pc_new;
        logic          branch;
        logic          reason;
        logic          hit1;
        logic          hit2;
        logic          dir1;
        bp_pkg::hist_t eff1;
        bp_pkg::hist_t eff2;
    } pred_t;

    logic               clk;
    logic               rstn;
    logic               en;
    bp_pkg::ex_update_t ex;
    bp_pkg::addr_t      pc;
    bp_pkg::addr_t      pc_new;
    logic               branch;
    logic               reason;

    logic [31:0] lfsr = 32'h999badc0;
    int          nchecks = 0;
    int          nerrors = 0;
    int          ntests = 0;
    int          test_err = 0;

    // Reference model of the tables, guess log, flags and fetch pc
    logic               b_vld [2][bp_pkg::ENTRIES];
    bp_pkg::tag_t       b_tag [2][bp_pkg::ENTRIES];
    bp_pkg::word_addr_t b_tgt [2][bp_pkg::ENTRIES];
    logic               b_unc [2][bp_pkg::ENTRIES];
    logic               b_cnd [2][bp_pkg::ENTRIES];
    logic               p_vld [2][bp_pkg::ENTRIES];
    logic [9:0]         p_pat [2][bp_pkg::ENTRIES];
    bp_pkg::guess_t     g_log [bp_pkg::ENTRIES];
    logic [31:0]        f1;
    logic [31:0]        f2;
    bp_pkg::addr_t      m_pc;

    clock_gen u_clk (.clk(clk), .rstn(rstn));

    fetch_predictor UUT (
        .clk    (clk),
        .rstn   (rstn),
        .en     (en),
        .ex     (ex),
        .pc     (pc),
        .pc_new (pc_new),
        .branch (branch),
        .reason (reason)
    );

    ////////////////////////////////////////
    // Random numbers
    ////////////////////////////////////////

    // Galois LFSR stepped once per bit taken
    function automatic logic [31:0] rand_bits(input int n);
        logic [31:0] r;
        r = '0;
        for (int k = 0; k < n; k++) begin
            r = {r[30:0], lfsr[0]};
            lfsr = lfsr[0] ? ((lfsr >> 1) ^ 32'hd0000001) : (lfsr >> 1);
        end
        return r;
    endfunction

    function automatic bp_pkg::addr_t rand_pc();
        logic [31:0] r;
        r = rand_bits(29);
        return {r[28:0], 3'b000};
    endfunction

    function automatic bp_pkg::word_addr_t rand_target();
        logic [31:0] r;
        r = rand_bits(30);
        return r[29:0];
    endfunction

    function automatic logic rand_bit();
        logic [31:0] r;
        r = rand_bits(1);
        return r[0];
    endfunction

    ////////////////////////////////////////
    // Reference model
    ////////////////////////////////////////

    function automatic logic ref_dir(input int s, input bp_pkg::addr_t p, input bp_pkg::hist_t h);
        logic [4:0] i;
        logic [9:0] bits;
        i = p[7:3];
        bits = p_pat[s][i];
        if (!(b_vld[s][i] && b_tag[s][i] == p[31:8])) begin
            return 1'b0;
        end
        if (p_vld[s][i]) begin
            return bits[2*h+1];
        end
        return b_unc[s][i] || (b_tgt[s][i] < p[31:2]);
    endfunction

    function automatic pred_t ref_predict(input bp_pkg::addr_t p);
        pred_t      r;
        logic [4:0] i;
        logic       dir2;
        i = p[7:3];
        r.eff1 = f1[i] ? g_log[i].g1 : p_pat[0][i][9:8];
        r.eff2 = f2[i] ? g_log[i].g2 : p_pat[1][i][9:8];
        r.hit1 = b_vld[0][i] && b_tag[0][i] == p[31:8];
        r.hit2 = b_vld[1][i] && b_tag[1][i] == p[31:8];
        r.dir1 = ref_dir(0, p, r.eff1);
        dir2 = ref_dir(1, p, r.eff2);
        r.branch = p[2] ? dir2 : (r.dir1 || dir2);
        r.reason = p[2] || (!r.dir1 && dir2);
        if (r.branch) begin
            r.pc_new = {b_tgt[r.reason][i], 2'b00};
        end else begin
            r.pc_new = {p[31:3], 3'b000} + 32'd8;
        end
        return r;
    endfunction

    task automatic model_reset();
        for (int s = 0; s < 2; s++) begin
            for (int i = 0; i < bp_pkg::ENTRIES; i++) begin
                b_vld[s][i] = 1'b0;
                p_vld[s][i] = 1'b0;
                p_pat[s][i] = 10'b00_01_01_01_01;
            end
        end
        f1 = '0;
        f2 = '0;
        m_pc = bp_pkg::RESET_PC;
    endtask

    // Applies the inputs that the DUT samples at the next rising edge
    task automatic model_step(input pred_t pr);
        logic [4:0]    i;
        logic [4:0]    wi;
        logic [9:0]    bits;
        bp_pkg::hist_t h;
        bp_pkg::ctr_t  c;
        i = m_pc[7:3];
        wi = ex.pc[7:3];
        if (en) begin
            g_log[i].g1 = {pr.eff1[0], pr.branch && !pr.reason};
            g_log[i].g2 = {pr.eff2[0], pr.branch && pr.reason};
        end
        if (ex.vld && ex.wrong) begin
            f1 = '0;
            f2 = '0;
        end else begin
            if (en && !m_pc[2] && pr.hit1 && p_vld[0][i] && b_cnd[0][i]) begin
                f1[i] = 1'b1;
            end
            if (en && !pr.dir1 && pr.hit2 && p_vld[1][i] && b_cnd[1][i]) begin
                f2[i] = 1'b1;
            end
        end
        if (ex.vld && (ex.taken || ex.uncond)) begin
            b_vld[ex.slot][wi] = 1'b1;
            b_tag[ex.slot][wi] = ex.pc[31:8];
            b_tgt[ex.slot][wi] = ex.target;
            b_unc[ex.slot][wi] = ex.uncond;
            b_cnd[ex.slot][wi] = ex.cond;
        end
        if (ex.vld && ex.cond) begin
            bits = p_pat[ex.slot][wi];
            h = bits[9:8];
            c = bits[2*h +: 2];
            if (ex.taken && c != 2'b11) begin
                c = c + 2'd1;
            end else if (!ex.taken && c != 2'b00) begin
                c = c - 2'd1;
            end
            bits[2*h +: 2] = c;
            bits[9:8] = {h[0], ex.taken};
            p_pat[ex.slot][wi] = bits;
            p_vld[ex.slot][wi] = 1'b1;
        end
        if (ex.vld && ex.wrong) begin
            m_pc = ex.redirect_pc;
        end else if (en) begin
            m_pc = pr.pc_new;
        end
    endtask

    ////////////////////////////////////////
    // Checks
    ////////////////////////////////////////

    task automatic check_addr(input string name, input bp_pkg::addr_t got,
                              input bp_pkg::addr_t exp);
        nchecks++;
        if (got !== exp) begin
            nerrors++;
            $display("ERROR %s got %h expected %h at %0t", name, got, exp, $time);
        end
    endtask

    task automatic check_bit(input string name, input logic got, input logic exp);
        nchecks++;
        if (got !== exp) begin
            nerrors++;
            $display("ERROR %s got %h expected %h at %0t", name, got, exp, $time);
        end
    endtask

    // Outputs are stable at the falling edge
    always @(negedge clk) begin : compare_step
        pred_t pr;
        if (rstn !== 1'b1) begin
            model_reset();
        end else begin
            pr = ref_predict(m_pc);
            check_addr("pc", pc, m_pc);
            check_addr("pc_new", pc_new, pr.pc_new);
            check_bit("branch", branch, pr.branch);
            check_bit("reason", reason, pr.reason);
            model_step(pr);
        end
    end

    ////////////////////////////////////////
    // Stimulus
    ////////////////////////////////////////

    function automatic bp_pkg::ex_update_t upd(
        input bp_pkg::addr_t      at,
        input logic               slot,
        input logic               taken,
        input bp_pkg::word_addr_t tgt,
        input logic               unc,
        input logic               cnd,
        input logic               wrong,
        input bp_pkg::addr_t      redir
    );
        bp_pkg::ex_update_t u;
        u.vld = 1'b1;
        u.wrong = wrong;
        u.pc = at;
        u.slot = slot;
        u.taken = taken;
        u.target = tgt;
        u.uncond = unc;
        u.cond = cnd;
        u.redirect_pc = redir;
        return u;
    endfunction

    task automatic drive(input logic e, input bp_pkg::ex_update_t u);
        @(posedge clk);
        en <= e;
        ex <= u;
    endtask

    task automatic run(input int n);
        repeat (n) drive(1'b1, '0);
    endtask

    // Redirect without any table write
    task automatic jump(input bp_pkg::addr_t to);
        drive(1'b1, upd(to, 1'b0, 1'b0, '0, 1'b0, 1'b0, 1'b1, to));
    endtask

    task automatic fetch_and_expect(input bp_pkg::addr_t at, input logic br, input logic rs,
                                    input bp_pkg::addr_t nx);
        drive(1'b1, '0);
        @(negedge clk);
        check_addr("pc", pc, at);
        check_bit("branch", branch, br);
        check_bit("reason", reason, rs);
        check_addr("pc_new", pc_new, nx);
    endtask

    task automatic end_test(input string name);
        ntests++;
        $display("test %0d %s: %0d errors", ntests, name, nerrors - test_err);
        test_err = nerrors;
    endtask

    initial begin : run_tests
        bp_pkg::addr_t      a;
        bp_pkg::addr_t      c;
        bp_pkg::word_addr_t t1;
        bp_pkg::word_addr_t t2;
        logic               s;
        en = 1'b0;
        ex = '0;
        wait (rstn === 1'b1);
        @(negedge clk);
        check_addr("pc", pc, bp_pkg::RESET_PC);
        run(8);
        repeat (4) drive(1'b0, '0);
        jump(bp_pkg::RESET_PC + 32'h104);
        run(4);
        end_test("reset and sequential fetch");

        a = rand_pc();
        s = rand_bit();
        t1 = rand_target();
        drive(1'b1, upd(a, s, 1'b1, t1, 1'b1, 1'b0, 1'b1, a));
        fetch_and_expect(a, 1'b1, s, {t1, 2'b00});
        a = rand_pc();
        drive(1'b1, upd(a, 1'b0, 1'b1, a[31:2] - 30'd5, 1'b0, 1'b0, 1'b1, a));
        fetch_and_expect(a, 1'b1, 1'b0, {a[31:2] - 30'd5, 2'b00});
        a = rand_pc();
        drive(1'b1, upd(a, 1'b0, 1'b1, a[31:2] + 30'd40, 1'b0, 1'b0, 1'b1, a));
        fetch_and_expect(a, 1'b0, 1'b0, a + 32'd8);
        end_test("btb install without history");

        a = rand_pc();
        t1 = rand_target();
        t2 = rand_target();
        drive(1'b1, upd(a, 1'b0, 1'b1, t1, 1'b1, 1'b0, 1'b0, '0));
        drive(1'b1, upd(a, 1'b1, 1'b1, t2, 1'b1, 1'b0, 1'b1, a));
        fetch_and_expect(a, 1'b1, 1'b0, {t1, 2'b00});
        jump(a + 32'd4);
        fetch_and_expect(a + 32'd4, 1'b1, 1'b1, {t2, 2'b00});
        a = rand_pc();
        t2 = rand_target();
        drive(1'b1, upd(a, 1'b0, 1'b1, a[31:2] + 30'd64, 1'b0, 1'b0, 1'b0, '0));
        drive(1'b1, upd(a, 1'b1, 1'b1, t2, 1'b1, 1'b0, 1'b1, a));
        fetch_and_expect(a, 1'b1, 1'b1, {t2, 2'b00});
        end_test("slot selection");

        // Self loop at c with c+8 jumping back to c
        c = rand_pc();
        s = rand_bit();
        drive(1'b1, upd(c + 32'd8, 1'b0, 1'b1, c[31:2], 1'b1, 1'b0, 1'b0, '0));
        drive(1'b1, upd(c, s, 1'b1, c[31:2], 1'b0, 1'b1, 1'b1, c));
        repeat (12) drive(1'b1, upd(c, s, rand_bit(), c[31:2], 1'b0, 1'b1, 1'b1, c));
        end_test("pht training");

        jump(c);
        run(10);
        repeat (2) drive(1'b0, '0);
        run(8);
        end_test("speculative guess history");

        a = rand_pc();
        drive(1'b1, upd(c, s, rand_bit(), c[31:2], 1'b0, 1'b1, 1'b1, a));
        drive(1'b1, '0);
        @(negedge clk);
        check_addr("pc", pc, a);
        jump(c);
        run(6);
        drive(1'b1, upd(c, s, rand_bit(), c[31:2], 1'b0, 1'b1, 1'b1, c));
        run(3);
        end_test("misprediction redirect");

        @(negedge clk);
        $display("%0d tests, %0d checks, %0d errors", ntests, nchecks, nerrors);
        if (nerrors == 0) begin
            $display("=== PASS ===");
        end else begin
            $display("=== FAIL ===");
        end
        $finish;
    end

    initial begin : watchdog
        #(WATCHDOG_CYC * 100);
        $display("Watchdog expired before the tests finished");
        $display("=== FAIL ===");
        $finish;
    end

endmodule

`default_nettype wire
